// File: vlog.f
design/etx_pkg.sv
design/etx_fifo.sv
design/etx_arbiter.sv
design/etx_cfg.sv
design/etx_top.sv
tb/etx_assertions.sv
tb/etx_tb.sv

// File: run.sh
#!/usr/bin/env bash
# Build and run the eMesh transmit simulation with Verilator
cd "$(dirname "$0")" || exit 1

rm -rf obj_dir sim.log build.log

verilator --binary --timing --assert --top-module etx_tb -f vlog.f -o etx_sim > build.log 2>&1 \
  && ./obj_dir/etx_sim > sim.log 2>&1 \
  && grep -q "TEST PASS" sim.log \
  && echo "simulation passed" \
  || { echo "simulation failed, see build.log and sim.log"; exit 1; }

// File: tb/etx_tb.sv
// eMesh transmit testbench
`timescale 1ns/1ns

module etx_tb;
  import etx_pkg::*;

  localparam int FIFO_DEPTH = 4;
  localparam int CH_WR = 0;
  localparam int CH_RD = 1;
  localparam int CH_RR = 2;
  localparam int LIMIT = 100;

  logic          tx_lclk_div4;
  logic          reset;
  logic          txwr_access;
  emesh_packet_t txwr_packet;
  logic          txwr_full;
  logic          txrd_access;
  emesh_packet_t txrd_packet;
  logic          txrd_full;
  logic          txrr_access;
  emesh_packet_t txrr_packet;
  logic          txrr_full;
  logic          cfg_write;
  logic [1:0]    cfg_addr;
  logic [15:0]   cfg_wdata;
  logic [15:0]   cfg_rdata;
  logic          etx_rd_wait;
  logic          etx_wr_wait;
  logic          etx_io_wait;
  logic          etx_access;
  emesh_packet_t etx_packet;
  logic          etx_rr;

  integer        seed;
  int            errors;
  int            checks;
  int            tests;
  int            test_err;
  string         test_name;
  int            sent [3];
  // Expected and observed transfers
  emesh_packet_t exp_pkt [$];
  logic          exp_rr [$];
  emesh_packet_t got_pkt [$];
  logic          got_rr [$];

  etx_top #(.FIFO_DEPTH(FIFO_DEPTH)) i_dut (.*);

  always #10 tx_lclk_div4 = ~tx_lclk_div4;

  // ##########################################################
  // Drive and compare helpers
  // ##########################################################
  // Inputs change 2 ns after the rising edge
  task automatic step();
    @(posedge tx_lclk_div4);
    #2;
  endtask

  task automatic check_packet(input string name, input emesh_packet_t exp,
                              input emesh_packet_t act);
    checks++;
    if (exp !== act)
    begin
      errors++;
      $display("** Error %s: expected %h, actual %h", name, exp, act);
    end
  endtask

  task automatic check_bit(input string name, input logic exp, input logic act);
    checks++;
    if (exp !== act)
    begin
      errors++;
      $display("** Error %s: expected %b, actual %b", name, exp, act);
    end
  endtask

  task automatic check_word(input string name, input logic [15:0] exp,
                            input logic [15:0] act);
    checks++;
    if (exp !== act)
    begin
      errors++;
      $display("** Error %s: expected %h, actual %h", name, exp, act);
    end
  endtask

  function automatic emesh_packet_t rand_packet(input logic wr);
    emesh_packet_t p;
    logic [31:0]   r;
    p.srcaddr  = $random(seed);
    p.data     = $random(seed);
    p.dstaddr  = $random(seed);
    r          = $random(seed);
    p.ctrlmode = r[3:0];
    p.spare    = 1'b0;
    p.datamode = r[5:4];
    p.write    = wr;
    return p;
  endfunction

  // One strobe into a channel FIFO
  task automatic push(input int ch, input emesh_packet_t p);
    step();
    case (ch)
      CH_WR:
      begin
        txwr_access = 1'b1;
        txwr_packet = p;
      end
      CH_RD:
      begin
        txrd_access = 1'b1;
        txrd_packet = p;
      end
      default:
      begin
        txrr_access = 1'b1;
        txrr_packet = p;
      end
    endcase
    sent[ch]++;
    step();
    txwr_access = 1'b0;
    txrd_access = 1'b0;
    txrr_access = 1'b0;
  endtask

  task automatic expect_out(input emesh_packet_t p, input logic rr);
    exp_pkt.push_back(p);
    exp_rr.push_back(rr);
  endtask

  task automatic set_waits(input logic wr, input logic rd, input logic io);
    step();
    etx_wr_wait = wr;
    etx_rd_wait = rd;
    etx_io_wait = io;
  endtask

  task automatic write_reg(input logic [1:0] addr, input logic [15:0] data);
    step();
    cfg_write = 1'b1;
    cfg_addr  = addr;
    cfg_wdata = data;
    step();
    cfg_write = 1'b0;
  endtask

  task automatic read_reg(input string name, input logic [1:0] addr,
                          input logic [15:0] exp);
    step();
    cfg_addr = addr;
    @(negedge tx_lclk_div4);
    check_word(name, exp, cfg_rdata);
  endtask

  // ##########################################################
  // Transfer monitor
  // ##########################################################
  // Sampled mid-cycle, access high and no IO stall
  task automatic collect(input int n);
    int waited;
    waited = 0;
    while ((got_pkt.size() < n) && (waited < LIMIT))
    begin
      @(negedge tx_lclk_div4);
      if (etx_access && !etx_io_wait)
      begin
        got_pkt.push_back(etx_packet);
        got_rr.push_back(etx_rr);
      end
      waited++;
    end
    if (got_pkt.size() < n)
    begin
      errors++;
      $display("%s: timed out, only %0d of %0d packets left the DUT",
               test_name, got_pkt.size(), n);
    end
  endtask

  task automatic wait_access();
    int waited;
    waited = 0;
    @(negedge tx_lclk_div4);
    while (!etx_access && (waited < LIMIT))
    begin
      @(negedge tx_lclk_div4);
      waited++;
    end
    if (!etx_access)
    begin
      errors++;
      $display("%s: timed out waiting for etx_access", test_name);
    end
  endtask

  task automatic compare_all();
    for (int i = 0; i < exp_pkt.size(); i++)
    begin
      if (i < got_pkt.size())
      begin
        check_packet(test_name, exp_pkt[i], got_pkt[i]);
        check_bit(test_name, exp_rr[i], got_rr[i]);
      end
    end
  endtask

  task automatic start_test(input string name);
    test_name = name;
    test_err  = errors;
    tests++;
    exp_pkt.delete();
    exp_rr.delete();
    got_pkt.delete();
    got_rr.delete();
    step();
  endtask

  task automatic finish_test();
    if (errors == test_err)
    begin
      $display("%s: passed", test_name);
    end
    else
    begin
      $display("%s: failed with %0d errors", test_name, errors - test_err);
    end
  endtask

  // ##########################################################
  // Directed tests
  // ##########################################################
  task automatic test_single();
    emesh_packet_t p;
    start_test("single_write");
    p = rand_packet(1'b1);
    expect_out(p, 1'b0);
    // Short IO stall first, packet must hold
    set_waits(1'b0, 1'b0, 1'b1);
    push(CH_WR, p);
    wait_access();
    repeat (3) step();
    @(negedge tx_lclk_div4);
    check_packet("single_write stall", p, etx_packet);
    set_waits(1'b0, 1'b0, 1'b0);
    collect(1);
    compare_all();
    read_reg("single_write count", CFG_WR_COUNT, 16'd1);
    finish_test();
  endtask

  task automatic test_priority();
    emesh_packet_t w [2];
    emesh_packet_t q [2];
    emesh_packet_t r [2];
    start_test("priority");
    set_waits(1'b1, 1'b1, 1'b1);
    for (int i = 0; i < 2; i++)
    begin
      w[i] = rand_packet(1'b1);
      q[i] = rand_packet(1'b0);
      r[i] = rand_packet(1'b1);
      push(CH_RR, r[i]);
      push(CH_RD, q[i]);
      push(CH_WR, w[i]);
    end
    // Writes, then read requests, then responses
    for (int i = 0; i < 2; i++)
    begin
      expect_out(w[i], 1'b0);
    end
    for (int i = 0; i < 2; i++)
    begin
      expect_out(q[i], 1'b0);
    end
    for (int i = 0; i < 2; i++)
    begin
      expect_out(r[i], 1'b1);
    end
    set_waits(1'b0, 1'b0, 1'b0);
    collect(6);
    compare_all();
    finish_test();
  endtask

  task automatic test_override();
    emesh_packet_t w;
    emesh_packet_t q;
    emesh_packet_t r;
    emesh_packet_t e;
    start_test("ctrlmode_override");
    // Bypass on, ctrlmode 4'ha
    write_reg(CFG_CTRL, 16'h001a);
    read_reg("ctrlmode_override ctrl", CFG_CTRL, 16'h001a);
    set_waits(1'b1, 1'b1, 1'b0);
    w = rand_packet(1'b1);
    q = rand_packet(1'b0);
    r = rand_packet(1'b1);
    // Source ctrlmode differs from the override value
    w.ctrlmode = 4'h5;
    q.ctrlmode = 4'h5;
    r.ctrlmode = 4'h5;
    push(CH_WR, w);
    push(CH_RD, q);
    push(CH_RR, r);
    e = w;
    e.ctrlmode = 4'ha;
    expect_out(e, 1'b0);
    e = q;
    e.ctrlmode = 4'ha;
    expect_out(e, 1'b0);
    // Responses pass untouched
    expect_out(r, 1'b1);
    set_waits(1'b0, 1'b0, 1'b0);
    collect(3);
    compare_all();
    write_reg(CFG_CTRL, 16'h0000);
    finish_test();
  endtask

  task automatic test_wait_gating();
    emesh_packet_t w;
    emesh_packet_t r;
    emesh_packet_t q [2];
    start_test("wait_gating");
    set_waits(1'b1, 1'b0, 1'b0);
    w    = rand_packet(1'b1);
    r    = rand_packet(1'b1);
    q[0] = rand_packet(1'b0);
    q[1] = rand_packet(1'b0);
    expect_out(q[0], 1'b0);
    expect_out(q[1], 1'b0);
    expect_out(w, 1'b0);
    expect_out(r, 1'b1);
    // Read requests drain while writes are held
    fork
      begin
        push(CH_WR, w);
        push(CH_RR, r);
        push(CH_RD, q[0]);
        push(CH_RD, q[1]);
      end
      collect(2);
    join
    set_waits(1'b0, 1'b0, 1'b0);
    collect(4);
    compare_all();
    finish_test();
  endtask

  task automatic test_full_order();
    emesh_packet_t w [FIFO_DEPTH];
    emesh_packet_t q [FIFO_DEPTH];
    emesh_packet_t r [FIFO_DEPTH];
    start_test("full_and_order");
    // All three channels held so every FIFO fills
    set_waits(1'b1, 1'b1, 1'b0);
    for (int i = 0; i < FIFO_DEPTH; i++)
    begin
      if (i == FIFO_DEPTH - 1)
      begin
        @(negedge tx_lclk_div4);
        check_bit("full_and_order wr not full", 1'b0, txwr_full);
        check_bit("full_and_order rd not full", 1'b0, txrd_full);
        check_bit("full_and_order rr not full", 1'b0, txrr_full);
      end
      w[i] = rand_packet(1'b1);
      q[i] = rand_packet(1'b0);
      r[i] = rand_packet(1'b1);
      push(CH_WR, w[i]);
      push(CH_RD, q[i]);
      push(CH_RR, r[i]);
    end
    @(negedge tx_lclk_div4);
    check_bit("full_and_order wr full", 1'b1, txwr_full);
    check_bit("full_and_order rd full", 1'b1, txrd_full);
    check_bit("full_and_order rr full", 1'b1, txrr_full);
    // Each channel drains in order, by priority
    for (int i = 0; i < FIFO_DEPTH; i++)
    begin
      expect_out(w[i], 1'b0);
    end
    for (int i = 0; i < FIFO_DEPTH; i++)
    begin
      expect_out(q[i], 1'b0);
    end
    for (int i = 0; i < FIFO_DEPTH; i++)
    begin
      expect_out(r[i], 1'b1);
    end
    set_waits(1'b0, 1'b0, 1'b0);
    collect(3 * FIFO_DEPTH);
    compare_all();
    read_reg("full_and_order wr count", CFG_WR_COUNT, 16'(sent[CH_WR]));
    read_reg("full_and_order rd count", CFG_RD_COUNT, 16'(sent[CH_RD]));
    read_reg("full_and_order rr count", CFG_RR_COUNT, 16'(sent[CH_RR]));
    finish_test();
  endtask

  initial
  begin
    seed         = 32'h5fed;
    errors       = 0;
    checks       = 0;
    tests        = 0;
    sent         = '{0, 0, 0};
    tx_lclk_div4 = 1'b0;
    reset        = 1'b1;
    txwr_access  = 1'b0;
    txwr_packet  = '0;
    txrd_access  = 1'b0;
    txrd_packet  = '0;
    txrr_access  = 1'b0;
    txrr_packet  = '0;
    cfg_write    = 1'b0;
    cfg_addr     = 2'd0;
    cfg_wdata    = 16'd0;
    etx_rd_wait  = 1'b0;
    etx_wr_wait  = 1'b0;
    etx_io_wait  = 1'b0;
    repeat (8) @(posedge tx_lclk_div4);
    #2;
    reset = 1'b0;
    test_single();
    test_priority();
    test_override();
    test_wait_gating();
    test_full_order();
    $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
    if (errors == 0)
    begin
      $display("TEST PASS");
    end
    else
    begin
      $display("TEST FAIL");
    end
    $finish;
  end

endmodule

// File: tb/etx_assertions.sv
// Arbiter protocol checks
`timescale 1ns/1ns

module etx_assertions (
  input logic                   tx_lclk_div4,
  input logic                   reset,
  input etx_pkg::etx_grant_t    grant,
  input logic                   txwr_fifo_read,
  input logic                   txwr_fifo_empty,
  input logic                   txrd_fifo_read,
  input logic                   txrd_fifo_empty,
  input logic                   txrr_fifo_read,
  input logic                   txrr_fifo_empty,
  input logic                   etx_access,
  input logic                   etx_io_wait,
  input etx_pkg::emesh_packet_t etx_packet
);
  import etx_pkg::*;

  logic [2:0] g;

  assign g = {grant.wr, grant.rd, grant.rr};

  // At most one channel popped per cycle
  a_grant_onehot: assert property (@(posedge tx_lclk_div4) disable iff (reset)
    $onehot0(g))
    else $error("grant has more than one bit set");

  // Pops only from FIFOs holding data
  a_read_not_empty: assert property (@(posedge tx_lclk_div4) disable iff (reset)
    !(txwr_fifo_read && txwr_fifo_empty) &&
    !(txrd_fifo_read && txrd_fifo_empty) &&
    !(txrr_fifo_read && txrr_fifo_empty))
    else $error("read pulse while FIFO empty");

  // Stalled output holds unless a new pop reloads it
  a_stall_hold: assert property (@(posedge tx_lclk_div4) disable iff (reset)
    (etx_access && etx_io_wait && (g == 3'b000)) |=> ($stable(etx_packet) && etx_access))
    else $error("output changed during IO stall");

endmodule

bind etx_arbiter etx_assertions i_assertions (
  .tx_lclk_div4(tx_lclk_div4), .reset(reset), .grant(grant),
  .txwr_fifo_read(txwr_fifo_read), .txwr_fifo_empty(txwr_fifo_empty),
  .txrd_fifo_read(txrd_fifo_read), .txrd_fifo_empty(txrd_fifo_empty),
  .txrr_fifo_read(txrr_fifo_read), .txrr_fifo_empty(txrr_fifo_empty),
  .etx_access(etx_access), .etx_io_wait(etx_io_wait), .etx_packet(etx_packet)
);

// File: design/etx_top.sv
// eMesh transmit top level
`timescale 1ns/1ns

module etx_top #(
  parameter int FIFO_DEPTH = 4
) (
  input  logic                   tx_lclk_div4,
  input  logic                   reset,
  // Host writes
  input  logic                   txwr_access,
  input  etx_pkg::emesh_packet_t txwr_packet,
  output logic                   txwr_full,
  // Host read requests
  input  logic                   txrd_access,
  input  etx_pkg::emesh_packet_t txrd_packet,
  output logic                   txrd_full,
  // Read responses
  input  logic                   txrr_access,
  input  etx_pkg::emesh_packet_t txrr_packet,
  output logic                   txrr_full,
  // Register port
  input  logic                   cfg_write,
  input  logic [1:0]             cfg_addr,
  input  logic [15:0]            cfg_wdata,
  output logic [15:0]            cfg_rdata,
  // IO side
  input  logic                   etx_rd_wait,
  input  logic                   etx_wr_wait,
  input  logic                   etx_io_wait,
  output logic                   etx_access,
  output etx_pkg::emesh_packet_t etx_packet,
  output logic                   etx_rr
);
  import etx_pkg::*;

  // FIFO heads and pops
  emesh_packet_t txwr_fifo_packet;
  emesh_packet_t txrd_fifo_packet;
  emesh_packet_t txrr_fifo_packet;
  logic          txwr_fifo_empty;
  logic          txrd_fifo_empty;
  logic          txrr_fifo_empty;
  logic          txwr_fifo_read;
  logic          txrd_fifo_read;
  logic          txrr_fifo_read;

  // Arbiter and config link
  etx_grant_t    grant;
  etx_ctrl_t     ctrl;

  // ##########################################################
  // Channel FIFOs
  // ##########################################################
  etx_fifo #(.DEPTH(FIFO_DEPTH)) i_txwr_fifo (
    .tx_lclk_div4, .reset,
    .access(txwr_access), .packet_in(txwr_packet), .full(txwr_full),
    .read(txwr_fifo_read), .packet_out(txwr_fifo_packet), .empty(txwr_fifo_empty)
  );

  etx_fifo #(.DEPTH(FIFO_DEPTH)) i_txrd_fifo (
    .tx_lclk_div4, .reset,
    .access(txrd_access), .packet_in(txrd_packet), .full(txrd_full),
    .read(txrd_fifo_read), .packet_out(txrd_fifo_packet), .empty(txrd_fifo_empty)
  );

  etx_fifo #(.DEPTH(FIFO_DEPTH)) i_txrr_fifo (
    .tx_lclk_div4, .reset,
    .access(txrr_access), .packet_in(txrr_packet), .full(txrr_full),
    .read(txrr_fifo_read), .packet_out(txrr_fifo_packet), .empty(txrr_fifo_empty)
  );

  // ##########################################################
  // Arbiter and configuration
  // ##########################################################
  etx_arbiter i_arbiter (
    .tx_lclk_div4, .reset, .ctrl,
    .txwr_fifo_empty, .txwr_fifo_packet, .txwr_fifo_read,
    .txrd_fifo_empty, .txrd_fifo_packet, .txrd_fifo_read,
    .txrr_fifo_empty, .txrr_fifo_packet, .txrr_fifo_read,
    .grant,
    .etx_rd_wait, .etx_wr_wait, .etx_io_wait,
    .etx_access, .etx_packet, .etx_rr
  );

  etx_cfg i_cfg (
    .tx_lclk_div4, .reset,
    .cfg_write, .cfg_addr, .cfg_wdata, .cfg_rdata,
    .grant, .ctrl
  );

endmodule

// File: design/etx_cfg.sv
// Transmit configuration registers
`timescale 1ns/1ns

module etx_cfg (
  input  logic                tx_lclk_div4,
  input  logic                reset,
  // Register port
  input  logic                cfg_write,
  input  logic [1:0]          cfg_addr,
  input  logic [15:0]         cfg_wdata,
  output logic [15:0]         cfg_rdata,
  // Pops from the arbiter
  input  etx_pkg::etx_grant_t grant,
  // Override level to the arbiter
  output etx_pkg::etx_ctrl_t  ctrl
);
  import etx_pkg::*;

  // Index 0 writes, 1 read requests, 2 read responses
  logic [15:0] count [3];
  logic [2:0]  hit;

  assign hit = {grant.rr, grant.rd, grant.wr};

  // ##########################################################
  // Control register
  // ##########################################################
  always_ff @(posedge tx_lclk_div4)
  begin
    if (reset)
    begin
      ctrl <= '0;
    end
    else if (cfg_write && (cfg_addr == CFG_CTRL))
    begin
      // Bypass in bit 4, ctrlmode below
      ctrl <= etx_ctrl_t'(cfg_wdata[4:0]);
    end
  end

  // ##########################################################
  // Packet counters
  // ##########################################################
  // Wrap at 16 bits, counter writes ignored
  always_ff @(posedge tx_lclk_div4)
  begin
    for (int i = 0; i < 3; i++)
    begin
      if (reset)
      begin
        count[i] <= '0;
      end
      else if (hit[i])
      begin
        count[i] <= count[i] + 16'd1;
      end
    end
  end

  // Read mux, combinational from address
  always_comb
  begin
    case (cfg_addr)
      CFG_CTRL:     cfg_rdata = {11'd0, ctrl};
      CFG_WR_COUNT: cfg_rdata = count[0];
      CFG_RD_COUNT: cfg_rdata = count[1];
      default:      cfg_rdata = count[2];
    endcase
  end

endmodule

// File: design/etx_arbiter.sv
// Transmit channel arbiter
`timescale 1ns/1ns

module etx_arbiter (
  input  logic                   tx_lclk_div4,
  input  logic                   reset,
  // Override from the config block
  input  etx_pkg::etx_ctrl_t     ctrl,
  // Host writes
  input  logic                   txwr_fifo_empty,
  input  etx_pkg::emesh_packet_t txwr_fifo_packet,
  output logic                   txwr_fifo_read,
  // Host read requests
  input  logic                   txrd_fifo_empty,
  input  etx_pkg::emesh_packet_t txrd_fifo_packet,
  output logic                   txrd_fifo_read,
  // Read responses
  input  logic                   txrr_fifo_empty,
  input  etx_pkg::emesh_packet_t txrr_fifo_packet,
  output logic                   txrr_fifo_read,
  // Pop marker for the counters
  output etx_pkg::etx_grant_t    grant,
  // IO side
  input  logic                   etx_rd_wait,
  input  logic                   etx_wr_wait,
  input  logic                   etx_io_wait,
  output logic                   etx_access,
  output etx_pkg::emesh_packet_t etx_packet,
  output logic                   etx_rr
);
  import etx_pkg::*;

  logic          wr_ready;
  logic          rd_ready;
  logic          rr_ready;
  logic          out_free;
  logic          pop;
  emesh_packet_t next_packet;

  // Swap in the configured ctrlmode when bypass is on
  function automatic emesh_packet_t host_override(emesh_packet_t pkt, etx_ctrl_t c);
    emesh_packet_t res;
    res = pkt;
    if (c.bypass)
    begin
      res.ctrlmode = c.ctrlmode;
    end
    return res;
  endfunction

  // ##########################################################
  // Fixed priority: writes, read requests, read responses
  // ##########################################################
  assign wr_ready = ~txwr_fifo_empty & ~etx_wr_wait;
  assign rd_ready = ~txrd_fifo_empty & ~etx_rd_wait & ~wr_ready;
  // Responses also wait on the write path
  assign rr_ready = ~txrr_fifo_empty & ~etx_wr_wait & ~wr_ready & ~rd_ready;

  // Output slot free when idle or stalled
  assign out_free = ~etx_access | etx_io_wait;

  // One-hot pops
  assign txwr_fifo_read = wr_ready & out_free;
  assign txrd_fifo_read = rd_ready & out_free;
  assign txrr_fifo_read = rr_ready & out_free;
  assign pop            = txwr_fifo_read | txrd_fifo_read | txrr_fifo_read;

  always_comb
  begin
    grant = '{wr: txwr_fifo_read, rd: txrd_fifo_read, rr: txrr_fifo_read};
  end

  // Packet mux, override for host packets only
  always_comb
  begin
    if (txrr_fifo_read)
    begin
      next_packet = txrr_fifo_packet;
    end
    else if (txrd_fifo_read)
    begin
      next_packet = host_override(txrd_fifo_packet, ctrl);
    end
    else
    begin
      next_packet = host_override(txwr_fifo_packet, ctrl);
    end
  end

  // ##########################################################
  // Registered IO output
  // ##########################################################
  always_ff @(posedge tx_lclk_div4)
  begin
    if (reset)
    begin
      etx_access <= 1'b0;
      etx_rr     <= 1'b0;
      etx_packet <= '0;
    end
    else if (pop)
    begin
      etx_access <= 1'b1;
      // Marks a read response for the IO side
      etx_rr     <= txrr_fifo_read;
      etx_packet <= next_packet;
    end
    else if (~etx_io_wait)
    begin
      etx_access <= 1'b0;
    end
  end

endmodule

// File: design/etx_fifo.sv
// Transmit packet FIFO
`timescale 1ns/1ns

module etx_fifo #(
  parameter int DEPTH = 4
) (
  input  logic                   tx_lclk_div4,
  input  logic                   reset,
  // Source side
  input  logic                   access,
  input  etx_pkg::emesh_packet_t packet_in,
  output logic                   full,
  // Arbiter side
  input  logic                   read,
  output etx_pkg::emesh_packet_t packet_out,
  output logic                   empty
);
  import etx_pkg::*;

  // Address bits, DEPTH is a power of two
  localparam int AW = $clog2(DEPTH);

  // Raw packet storage
  logic [PW-1:0] mem [DEPTH];

  // Extra top bit tells full from empty
  logic [AW:0] wr_ptr;
  logic [AW:0] rd_ptr;

  logic wr_en;
  logic rd_en;

  // Drop writes while full
  assign wr_en = access & ~full;
  // Guard against reads while empty
  assign rd_en = read & ~empty;

  // Same pointer means nothing stored
  assign empty = (wr_ptr == rd_ptr);
  // Wrapped once, same slot
  assign full = (wr_ptr[AW] != rd_ptr[AW]) &&
                (wr_ptr[AW-1:0] == rd_ptr[AW-1:0]);

  // Head entry shown directly, first-word fall-through
  assign packet_out = emesh_packet_t'(mem[rd_ptr[AW-1:0]]);

  // Pointer update, push and pop may share a cycle
  always_ff @(posedge tx_lclk_div4)
  begin
    if (reset)
    begin
      wr_ptr <= '0;
      rd_ptr <= '0;
    end
    else
    begin
      if (wr_en)
      begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (rd_en)
      begin
        rd_ptr <= rd_ptr + 1'b1;
      end
    end
  end

  // Storage write
  always_ff @(posedge tx_lclk_div4)
  begin
    if (wr_en)
    begin
      mem[wr_ptr[AW-1:0]] <= packet_in;
    end
  end

endmodule

// File: design/etx_pkg.sv
// eMesh transmit shared types
package etx_pkg;

  // ##########################################################
  // Packet format
  // ##########################################################

  // Packet width in bits
  localparam int PW = 104;

  // Field order from the top bit down
  typedef struct packed {
    logic [31:0] srcaddr;
    logic [31:0] data;
    logic [31:0] dstaddr;
    logic [3:0]  ctrlmode;   // Bits 7 to 4
    logic        spare;
    logic [1:0]  datamode;
    logic        write;      // Bit 0
  } emesh_packet_t;

  // Control-mode override for host packets
  typedef struct packed {
    logic       bypass;
    logic [3:0] ctrlmode;
  } etx_ctrl_t;

  // Channel popped this cycle, one-hot or zero
  typedef struct packed {
    logic wr;
    logic rd;
    logic rr;
  } etx_grant_t;

  // ##########################################################
  // Configuration register map
  // ##########################################################
  localparam logic [1:0] CFG_CTRL     = 2'd0;
  localparam logic [1:0] CFG_WR_COUNT = 2'd1;
  localparam logic [1:0] CFG_RD_COUNT = 2'd2;
  localparam logic [1:0] CFG_RR_COUNT = 2'd3;

endpackage
